// ==== uart_pkg.sv ====
//**************************************************
// serial link definitions
// frame layout, line levels and the byte type shared
// by the receiver, the transmitter and the top level
//**************************************************
package uart_pkg;

	// data bits carried in each frame
	parameter int DATA_BITS = 8;

	// start + data + stop, no parity
	parameter int FRAME_BITS = DATA_BITS + 2;

	// line level of the start bit
	parameter logic START_LEVEL = 1'b0;

	// line level of the stop bit, also the idle level
	parameter logic STOP_LEVEL = 1'b1;

	// one byte on the wire
	typedef logic [DATA_BITS-1:0] uart_byte_t;

endpackage

// ==== disp_pkg.sv ====
//**************************************************
// seven-segment display definitions
// active-low glyphs in {dp,g,f,e,d,c,b,a} order
//**************************************************
package disp_pkg;

	// digits on the board
	parameter int DIGITS = 8;

	// one hex nibble per digit
	typedef logic [3:0] digit_t;

	// every segment dark
	parameter logic [7:0] BLANK_GLYPH = 8'hff;

	// "U" marker, segments b..f lit
	parameter logic [7:0] MARK_GLYPH = 8'hc1;

	// hex nibble to segment pattern, dp kept off
	function automatic logic [7:0] hex_glyph(input digit_t code);
		logic [7:0] pat;
		case (code)
			4'h0: pat = 8'hc0;
			4'h1: pat = 8'hf9;
			4'h2: pat = 8'ha4;
			4'h3: pat = 8'hb0;
			4'h4: pat = 8'h99;
			4'h5: pat = 8'h92;
			4'h6: pat = 8'h82;
			4'h7: pat = 8'hf8;
			4'h8: pat = 8'h80;
			4'h9: pat = 8'h90;
			4'ha: pat = 8'h88;
			4'hb: pat = 8'h83;
			4'hc: pat = 8'hc6;
			4'hd: pat = 8'ha1;
			4'he: pat = 8'h86;
			default: pat = 8'h8e;
		endcase
		return pat;
	endfunction

endpackage

// ==== key_debounce.sv ====
//**************************************************
// key debouncer
// syncs four active-low keys, filters bounce, makes
// press strobes and toggles one LED per key
//**************************************************
`timescale 1ns/1ps

module key_debounce #(
	parameter int DEBOUNCE_CYCLES = 1_000_000
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [3:0] key_in,
	output logic [3:0] key_level,
	output logic [3:0] key_press,
	output logic [7:0] led
);

	// counter only has to reach DEBOUNCE_CYCLES-1
	localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

	logic [3:0] sync_a;
	logic [3:0] sync_b;
	logic [3:0] sample;
	logic [3:0] level_q;
	logic [3:0] press_q;
	logic [3:0] toggle_q;
	logic [CNT_W-1:0] cnt [4];

	// two-flop synchronizer, keys idle high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sync_a <= '1;
			sync_b <= '1;
		end else begin
			sync_a <= key_in;
			sync_b <= sync_a;
		end
	end

	// 1 = pressed from here on
	assign sample = ~sync_b;

	// per key stable counter, runs only while sample differs from level
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			level_q  <= '0;
			press_q  <= '0;
			toggle_q <= '0;
			for (int i = 0; i < 4; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			press_q <= '0;
			for (int i = 0; i < 4; i++) begin
				if (sample[i] == level_q[i]) begin
					// bounce back, start over
					cnt[i] <= '0;
				end else if (cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
					cnt[i]     <= '0;
					level_q[i] <= sample[i];
					// rising level gives the press strobe and the LED toggle
					if (sample[i]) begin
						press_q[i]  <= 1'b1;
						toggle_q[i] <= ~toggle_q[i];
					end
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

	assign key_level = level_q;
	assign key_press = press_q;
	// upper LEDs follow the held keys
	assign led = {level_q, toggle_q};

endmodule

// ==== uart_rx.sv ====
//**************************************************
// UART receiver, 8N1
// samples each bit at its middle, strobes a byte out
// only when the stop bit reads high
//**************************************************
`timescale 1ns/1ps

module uart_rx #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  logic                  uart_rx_port,
	output uart_pkg::uart_byte_t  rx_data,
	output logic                  rx_valid
);

	localparam int HALF_BIT = CLKS_PER_BIT / 2;
	localparam int TMR_W    = $clog2(CLKS_PER_BIT);
	localparam int BIT_W    = $clog2(uart_pkg::DATA_BITS);

	// fsm states
	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_START = 2'd1;
	localparam logic [1:0] ST_DATA  = 2'd2;
	localparam logic [1:0] ST_STOP  = 2'd3;

	logic [1:0]           state;
	logic [1:0]           line_sync;
	logic                 line_s;
	logic [TMR_W-1:0]     tmr;
	logic [BIT_W-1:0]     bit_cnt;
	uart_pkg::uart_byte_t shift_q;
	logic                 valid_q;

	// line comes from another clock domain, idle high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			line_sync <= 2'b11;
		end else begin
			line_sync <= {line_sync[0], uart_rx_port};
		end
	end

	assign line_s = line_sync[1];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= ST_IDLE;
			tmr     <= '0;
			bit_cnt <= '0;
			shift_q <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					tmr <= '0;
					// falling edge of a start bit
					if (line_s == uart_pkg::START_LEVEL) state <= ST_START;
				end
				ST_START: begin
					if (tmr == TMR_W'(HALF_BIT - 1)) begin
						tmr     <= '0;
						bit_cnt <= '0;
						// high at mid start is only a glitch
						state   <= (line_s == uart_pkg::START_LEVEL) ? ST_DATA : ST_IDLE;
					end else begin
						tmr <= tmr + 1'b1;
					end
				end
				ST_DATA: begin
					if (tmr == TMR_W'(CLKS_PER_BIT - 1)) begin
						tmr <= '0;
						// lsb arrives first
						shift_q <= {line_s, shift_q[uart_pkg::DATA_BITS-1:1]};
						if (bit_cnt == BIT_W'(uart_pkg::DATA_BITS - 1)) state <= ST_STOP;
						else bit_cnt <= bit_cnt + 1'b1;
					end else begin
						tmr <= tmr + 1'b1;
					end
				end
				default: begin
					if (tmr == TMR_W'(CLKS_PER_BIT - 1)) begin
						tmr     <= '0;
						state   <= ST_IDLE;
						// framing error drops the byte silently
						valid_q <= (line_s == uart_pkg::STOP_LEVEL);
					end else begin
						tmr <= tmr + 1'b1;
					end
				end
			endcase
		end
	end

	assign rx_data  = shift_q;
	assign rx_valid = valid_q;

endmodule

// ==== uart_tx.sv ====
//**************************************************
// UART transmitter, 8N1
// shifts out one frame per start strobe, lsb first
//**************************************************
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic                 tx_start,
	input  uart_pkg::uart_byte_t tx_data,
	output logic                 tx_busy,
	output logic                 uart_tx_port
);

	localparam int TMR_W = $clog2(CLKS_PER_BIT);
	localparam int CNT_W = $clog2(uart_pkg::FRAME_BITS);

	// bit 0 is always the bit on the wire
	logic [uart_pkg::FRAME_BITS-1:0] frame_q;
	logic [TMR_W-1:0]                tmr;
	logic [CNT_W-1:0]                bit_cnt;
	logic                            busy_q;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			frame_q <= '1;
			tmr     <= '0;
			bit_cnt <= '0;
			busy_q  <= 1'b0;
		end else if (!busy_q) begin
			// start strobe while busy is simply ignored
			if (tx_start) begin
				frame_q <= {uart_pkg::STOP_LEVEL, tx_data, uart_pkg::START_LEVEL};
				tmr     <= '0;
				bit_cnt <= '0;
				busy_q  <= 1'b1;
			end
		end else if (tmr == TMR_W'(CLKS_PER_BIT - 1)) begin
			tmr <= '0;
			// refill with idle level as bits leave
			frame_q <= {uart_pkg::STOP_LEVEL, frame_q[uart_pkg::FRAME_BITS-1:1]};
			// free again once the stop bit has run its full time
			if (bit_cnt == CNT_W'(uart_pkg::FRAME_BITS - 1)) busy_q <= 1'b0;
			else bit_cnt <= bit_cnt + 1'b1;
		end else begin
			tmr <= tmr + 1'b1;
		end
	end

	assign uart_tx_port = frame_q[0];
	assign tx_busy      = busy_q;

endmodule

// ==== seg_scan.sv ====
//**************************************************
// seven-segment scanner
// builds the eight digit glyphs and multiplexes them
// onto the shared segment and select lines
//**************************************************
`timescale 1ns/1ps

module seg_scan #(
	parameter int SCAN_CYCLES = 50_000
) (
	input  logic                        sys_clk,
	input  logic                        sys_rst_n,
	input  uart_pkg::uart_byte_t        rx_byte,
	input  uart_pkg::uart_byte_t        rx_count,
	input  logic [3:0]                  key_level,
	output logic [7:0]                  seg_number,
	output logic [disp_pkg::DIGITS-1:0] seg_choice
);

	localparam int IDX_W = $clog2(disp_pkg::DIGITS);
	localparam int CNT_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;

	logic [7:0]       glyph [disp_pkg::DIGITS];
	logic [CNT_W-1:0] scan_cnt;
	logic [IDX_W-1:0] idx_q;
	logic [IDX_W-1:0] idx_next;

	// digit contents, digit 0 is the rightmost
	always_comb begin
		glyph[0] = disp_pkg::hex_glyph(rx_byte[3:0]);
		glyph[1] = disp_pkg::hex_glyph(rx_byte[7:4]);
		glyph[2] = disp_pkg::hex_glyph(rx_count[3:0]);
		glyph[3] = disp_pkg::hex_glyph(rx_count[7:4]);
		glyph[4] = disp_pkg::hex_glyph(key_level);
		// two spacer digits
		glyph[5] = disp_pkg::BLANK_GLYPH;
		glyph[6] = disp_pkg::BLANK_GLYPH;
		glyph[7] = disp_pkg::MARK_GLYPH;
	end

	// next digit once the slot time is used up
	always_comb begin
		idx_next = idx_q;
		if (scan_cnt == CNT_W'(SCAN_CYCLES - 1)) begin
			if (idx_q == IDX_W'(disp_pkg::DIGITS - 1)) idx_next = '0;
			else idx_next = idx_q + 1'b1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scan_cnt   <= '0;
			idx_q      <= '0;
			seg_number <= disp_pkg::BLANK_GLYPH;
			seg_choice <= ~disp_pkg::DIGITS'(1);
		end else begin
			if (scan_cnt == CNT_W'(SCAN_CYCLES - 1)) scan_cnt <= '0;
			else scan_cnt <= scan_cnt + 1'b1;
			idx_q <= idx_next;
			// glyph and select leave on the same edge, glyph refreshed every cycle
			seg_number <= glyph[idx_next];
			seg_choice <= ~(disp_pkg::DIGITS'(1) << idx_next);
		end
	end

endmodule

// ==== beeper.sv ====
//**************************************************
// key beeper
// square tone gated by a window that each start
// strobe restarts
//**************************************************
`timescale 1ns/1ps

module beeper #(
	parameter int BEEP_CYCLES = 5_000_000,
	parameter int TONE_HALF   = 12_500
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic start,
	output logic beeper
);

	localparam int WIN_W  = $clog2(BEEP_CYCLES + 1);
	localparam int TONE_W = (TONE_HALF > 1) ? $clog2(TONE_HALF) : 1;

	logic [WIN_W-1:0]  win_cnt;
	logic [TONE_W-1:0] tone_cnt;
	logic              tone_q;
	logic              beep_q;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			win_cnt  <= '0;
			tone_cnt <= '0;
			tone_q   <= 1'b0;
			beep_q   <= 1'b0;
		end else begin
			// new press restarts the window
			if (start) win_cnt <= WIN_W'(BEEP_CYCLES);
			else if (win_cnt != '0) win_cnt <= win_cnt - 1'b1;
			// tone divider runs freely
			if (tone_cnt == TONE_W'(TONE_HALF - 1)) begin
				tone_cnt <= '0;
				tone_q   <= ~tone_q;
			end else begin
				tone_cnt <= tone_cnt + 1'b1;
			end
			beep_q <= (win_cnt != '0) & tone_q;
		end
	end

	assign beeper = beep_q;

endmodule

// ==== panel_top.sv ====
//**************************************************
// front-panel controller top
// keys, LEDs, beeper, UART echo and the eight-digit
// display, with the receive counter and echo logic
//**************************************************
`timescale 1ns/1ps

module panel_top #(
	// defaults for a 50 MHz board, 115200 baud
	parameter int CLKS_PER_BIT    = 434,
	parameter int DEBOUNCE_CYCLES = 1_000_000,
	parameter int SCAN_CYCLES     = 50_000,
	parameter int BEEP_CYCLES     = 5_000_000,
	parameter int TONE_HALF       = 12_500
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [3:0] key_in,
	input  logic       uart_rx_port,
	output logic       uart_tx_port,
	output logic [7:0] led,
	output logic       beeper,
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice
);

	logic [3:0]           key_level;
	logic [3:0]           key_press;
	uart_pkg::uart_byte_t rx_data;
	logic                 rx_valid;
	logic                 tx_busy;
	logic                 tx_start;
	uart_pkg::uart_byte_t rx_byte_q;
	uart_pkg::uart_byte_t rx_count_q;

	// latch each good byte, count it, echo it if the transmitter is free
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_byte_q  <= '0;
			rx_count_q <= '0;
			tx_start   <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			if (rx_valid) begin
				rx_byte_q  <= rx_data;
				rx_count_q <= rx_count_q + 1'b1;
				// busy transmitter means this byte is shown but not echoed
				tx_start   <= ~tx_busy;
			end
		end
	end

	key_debounce #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) i_key_debounce (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key_in    (key_in),
		.key_level (key_level),
		.key_press (key_press),
		.led       (led)
	);

	uart_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_uart_rx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (uart_rx_port),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid)
	);

	// echo path, byte taken from the latched copy
	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_uart_tx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_start     (tx_start),
		.tx_data      (rx_byte_q),
		.tx_busy      (tx_busy),
		.uart_tx_port (uart_tx_port)
	);

	seg_scan #(
		.SCAN_CYCLES (SCAN_CYCLES)
	) i_seg_scan (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.rx_byte    (rx_byte_q),
		.rx_count   (rx_count_q),
		.key_level  (key_level),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

	// any key press beeps
	beeper #(
		.BEEP_CYCLES (BEEP_CYCLES),
		.TONE_HALF   (TONE_HALF)
	) i_beeper (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.start     (|key_press),
		.beeper    (beeper)
	);

endmodule

// ==== tb_panel_top.sv ====
//**************************************************
// panel controller testbench
// UART host and echo monitor, key bounce stimulus,
// display, LED and beeper checks by assertions
//**************************************************
`timescale 1ns/1ps

module tb_panel_top;

	localparam int CLK_NS          = 20;
	localparam int CLKS_PER_BIT    = 8;
	localparam int DEBOUNCE_CYCLES = 20;
	localparam int SCAN_CYCLES     = 4;
	localparam int BEEP_CYCLES     = 200;
	localparam int TONE_HALF       = 5;
	localparam int BIT_NS          = CLKS_PER_BIT * CLK_NS;
	localparam int N_FRAMES        = 10;
	// frame 4 goes out with a low stop bit
	localparam int BAD_FRAME       = 4;
	localparam int ROUND_CYC       = 2 * disp_pkg::DIGITS * SCAN_CYCLES;
	localparam int FRAME_CYC       = (uart_pkg::FRAME_BITS + 3) * CLKS_PER_BIT + ROUND_CYC + 4;
	localparam int KEY_CYC         = 6 * DEBOUNCE_CYCLES + BEEP_CYCLES + 4 * TONE_HALF
	                                 + ROUND_CYC + 40;
	localparam int RUN_CYC         = 10 + ROUND_CYC + N_FRAMES * FRAME_CYC + 4 * KEY_CYC
	                                 + 4 * uart_pkg::FRAME_BITS * CLKS_PER_BIT;
	// twice the expected run length
	localparam int WATCHDOG_NS     = 2 * RUN_CYC * CLK_NS;

	logic       sys_clk = 1'b0;
	logic       sys_rst_n;
	logic [3:0] key_in;
	logic       uart_rx_port;
	logic       uart_tx_port;
	logic [7:0] led;
	logic       beeper;
	logic [7:0] seg_number;
	logic [7:0] seg_choice;

	// reference model of what the display should show
	uart_pkg::uart_byte_t exp_byte;
	uart_pkg::uart_byte_t exp_count;
	logic [3:0]           exp_keys;
	logic                 disp_en;

	// LED state the clean presses should leave behind
	logic [7:0]           exp_led;

	uart_pkg::uart_byte_t sent_q [$];
	logic [31:0]          rng = 32'h75e598df;
	int                   cyc = 0;
	int                   mismatch_count = 0;
	int                   fail_count = 0;

	panel_top #(
		.CLKS_PER_BIT    (CLKS_PER_BIT),
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.SCAN_CYCLES     (SCAN_CYCLES),
		.BEEP_CYCLES     (BEEP_CYCLES),
		.TONE_HALF       (TONE_HALF)
	) i_panel_top (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.key_in       (key_in),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port),
		.led          (led),
		.beeper       (beeper),
		.seg_number   (seg_number),
		.seg_choice   (seg_choice)
	);

	always #(CLK_NS / 2) sys_clk = ~sys_clk;

	always @(posedge sys_clk) cyc <= cyc + 1;

	task automatic log_mismatch(input string name, input logic [7:0] want, input logic [7:0] got);
		mismatch_count++;
		$display("MISMATCH at %0t: %s expected 0x%02h, got 0x%02h", $time, name, want, got);
	endtask

	task automatic note_failure(input string text);
		fail_count++;
		$display("ERROR at %0t: %s", $time, text);
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// expected glyph for whichever digit is selected
	function automatic logic [7:0] digit_model(input logic [7:0] sel);
		logic [7:0] glyph;
		glyph = disp_pkg::BLANK_GLYPH;
		for (int d = 0; d < disp_pkg::DIGITS; d++) begin
			if (!sel[d]) begin
				case (d)
					0: glyph = disp_pkg::hex_glyph(exp_byte[3:0]);
					1: glyph = disp_pkg::hex_glyph(exp_byte[7:4]);
					2: glyph = disp_pkg::hex_glyph(exp_count[3:0]);
					3: glyph = disp_pkg::hex_glyph(exp_count[7:4]);
					4: glyph = disp_pkg::hex_glyph(exp_keys);
					7: glyph = disp_pkg::MARK_GLYPH;
					default: glyph = disp_pkg::BLANK_GLYPH;
				endcase
			end
		end
		return glyph;
	endfunction

	// active-low select moves one digit up
	function automatic logic [7:0] rotate_select(input logic [7:0] sel);
		return {sel[6:0], sel[7]};
	endfunction

	// display outputs sampled mid-cycle, away from the driving edge
	assert property (@(negedge sys_clk) disable iff (!sys_rst_n)
		$onehot(~seg_choice))
	else note_failure("seg_choice is not one-hot low");

	assert property (@(negedge sys_clk) disable iff (!sys_rst_n)
		!$stable(seg_choice) |-> seg_choice == rotate_select($past(seg_choice)))
	else note_failure("seg_choice skipped a digit or moved downward");

	assert property (@(negedge sys_clk) disable iff (!sys_rst_n)
		(disp_en && $stable(seg_choice)) |-> seg_number == digit_model(seg_choice))
	else log_mismatch("seg_number", digit_model(seg_choice), seg_number);

	// one UART bit on the host line, changed just after the edge
	task automatic hold_line(input logic level);
		@(posedge sys_clk);
		#2;
		uart_rx_port = level;
		repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);
	endtask

	task automatic send_frame(input uart_pkg::uart_byte_t data, input logic good);
		@(posedge sys_clk);
		#2;
		disp_en = 1'b0;
		if (good) sent_q.push_back(data);
		hold_line(uart_pkg::START_LEVEL);
		for (int i = 0; i < uart_pkg::DATA_BITS; i++) hold_line(data[i]);
		hold_line(good);
		// idle gap of three bits
		repeat (3) hold_line(1'b1);
		@(posedge sys_clk);
		#2;
		if (good) begin
			exp_byte  = data;
			exp_count = exp_count + 8'd1;
		end
		// a bad frame leaves the model as it was
		disp_en = 1'b1;
		repeat (ROUND_CYC) @(posedge sys_clk);
	endtask

	// short low pulses on one key, none long enough to count
	task automatic bounce_key(input int k);
		int len;
		repeat (2) begin
			rng = xorshift32(rng);
			len = 1 + int'(rng[15:0]) % (DEBOUNCE_CYCLES - 1);
			@(posedge sys_clk);
			#2;
			key_in[k] = 1'b0;
			repeat (len) @(posedge sys_clk);
			#2;
			key_in[k] = 1'b1;
			rng = xorshift32(rng);
			len = 1 + int'(rng[15:0]) % (DEBOUNCE_CYCLES - 1);
			repeat (len) @(posedge sys_clk);
		end
		repeat (DEBOUNCE_CYCLES + 5) @(posedge sys_clk);
		@(negedge sys_clk);
		assert (led === exp_led) else log_mismatch("led after bounce", exp_led, led);
	endtask

	// clean press and release, with LED, digit 4 and beeper checks
	task automatic press_key(input int k);
		int t0;
		int waited;
		exp_led[k]     = ~exp_led[k];
		exp_led[4 + k] = 1'b1;
		@(posedge sys_clk);
		#2;
		key_in[k] = 1'b0;
		t0 = cyc;
		// sync delay plus debounce, with a little slack
		repeat (DEBOUNCE_CYCLES + 8) @(posedge sys_clk);
		@(negedge sys_clk);
		assert (led === exp_led) else log_mismatch("led after press", exp_led, led);
		waited = 0;
		while (beeper !== 1'b1 && waited < BEEP_CYCLES) begin
			@(negedge sys_clk);
			waited++;
		end
		assert (beeper === 1'b1) else note_failure("beeper did not toggle after a key press");
		@(posedge sys_clk);
		#2;
		exp_keys[k] = 1'b1;
		disp_en     = 1'b1;
		repeat (ROUND_CYC) @(posedge sys_clk);
		#2;
		disp_en     = 1'b0;
		exp_keys[k] = 1'b0;
		key_in[k]   = 1'b1;
		// window over, tone must be gone
		while (cyc < t0 + DEBOUNCE_CYCLES + BEEP_CYCLES + 20) @(negedge sys_clk);
		repeat (2 * TONE_HALF + 2) begin
			@(negedge sys_clk);
			assert (beeper === 1'b0) else log_mismatch("beeper", 8'h00, {7'd0, beeper});
		end
		exp_led[4 + k] = 1'b0;
		assert (led === exp_led) else log_mismatch("led after release", exp_led, led);
	endtask

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	// decodes every echo frame at mid-bit and checks it against the sent bytes
	initial begin : echo_monitor
		uart_pkg::uart_byte_t got;
		uart_pkg::uart_byte_t want;
		@(posedge sys_rst_n);
		forever begin
			@(negedge uart_tx_port);
			#(BIT_NS / 2 + CLK_NS / 2);
			assert (uart_tx_port === 1'b0) else note_failure("echo start bit did not hold low");
			for (int i = 0; i < uart_pkg::DATA_BITS; i++) begin
				#(BIT_NS);
				got[i] = uart_tx_port;
			end
			#(BIT_NS);
			assert (uart_tx_port === 1'b1) else note_failure("echo frame has a low stop bit");
			if (sent_q.size() == 0) begin
				note_failure("echo seen with no byte waiting for it");
			end else begin
				want = sent_q.pop_front();
				assert (got == want) else log_mismatch("uart_tx_port byte", want, got);
			end
		end
	end

	initial begin : stimulus
		sys_rst_n    = 1'b0;
		key_in       = 4'hf;
		uart_rx_port = 1'b1;
		exp_byte     = '0;
		exp_count    = '0;
		exp_keys     = '0;
		exp_led      = '0;
		disp_en      = 1'b0;
		repeat (9) @(posedge sys_clk);
		@(negedge sys_clk);
		// reset values
		assert (led === 8'h00) else log_mismatch("led", 8'h00, led);
		assert (beeper === 1'b0) else log_mismatch("beeper", 8'h00, {7'd0, beeper});
		assert (uart_tx_port === 1'b1) else log_mismatch("uart_tx_port", 8'h01, {7'd0, uart_tx_port});
		assert (seg_choice === 8'hfe) else log_mismatch("seg_choice", 8'hfe, seg_choice);
		@(posedge sys_clk);
		#2;
		sys_rst_n = 1'b1;
		// display is blank in reset, first glyph loads on the next edge
		@(posedge sys_clk);
		#2;
		disp_en   = 1'b1;
		repeat (ROUND_CYC) @(posedge sys_clk);
		for (int n = 0; n < N_FRAMES; n++) begin
			rng = xorshift32(rng);
			send_frame(rng[7:0], n != BAD_FRAME);
		end
		disp_en = 1'b0;
		for (int k = 0; k < 4; k++) begin
			bounce_key(k);
			press_key(k);
		end
		// let the last echo drain
		repeat (4 * uart_pkg::FRAME_BITS * CLKS_PER_BIT) @(posedge sys_clk);
		assert (sent_q.size() == 0) else note_failure("a sent byte was never echoed");
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if (mismatch_count + fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== build.f ====
uart_pkg.sv
disp_pkg.sv
key_debounce.sv
uart_rx.sv
uart_tx.sv
seg_scan.sv
beeper.sv
panel_top.sv
tb_panel_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the panel testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module tb_panel_top -o tb_panel_top; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/tb_panel_top > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi

cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi

exit 0
